//--- all.f
+incdir+src
src/cpu_pkg.sv
src/register_file.sv
src/alu.sv
src/cpu_sequencer.sv
src/pc_sp_counter.sv
src/instruction_decoder.sv
src/cpu_top.sv
test/cpu_tb_chk.sv
test/cpu_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS = --binary --timing --assert
LINT_FLAGS = --lint-only --timing -Wall
TOP = cpu_tb
FILELIST = all.f
OBJ_DIR = obj_dir
PASS_MSG = all tests passed

.PHONY: all lint clean

all:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- test/cpu_tb.sv
`timescale 1ns/10ps
`include "cpu_settings.svh"

module cpu_tb;

	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 10;
	localparam int NUM_TESTS = 6;
	localparam int MAX_INSNS = 160;
	// at most 3 cycles per instruction, plus reset and idle tails
	localparam int WATCHDOG_CYCLES = NUM_TESTS * (RESET_CYCLES + 3 * MAX_INSNS + 40) + 100;
	localparam logic [15:0] PUSH_ADDR = `CPU_STACK_RESET - 16'd2;

	logic clk;
	logic reset;
	logic [`CPU_DATA_WIDTH-1:0] iread_addr;
	logic [`CPU_INST_WIDTH-1:0] iread_data = '0;
	logic [`CPU_DATA_WIDTH-1:0] dread_addr;
	logic [`CPU_DATA_WIDTH-1:0] dread_data = '0;
	logic [`CPU_DATA_WIDTH-1:0] dwrite_addr;
	logic [`CPU_DATA_WIDTH-1:0] dwrite_data;
	logic [1:0] dwrite_en;
	logic interrupt;
	logic trap;

	logic [7:0] imem [0:65535];
	logic [7:0] dmem [0:65535];
	logic [15:0] asm_addr;
	int insn_count;
	int errors;
	int errors_at_start;
	int tests_run;
	int tests_failed;
	logic [15:0] log_addr [$];
	logic [15:0] log_data [$];
	logic [1:0] log_en [$];
	logic [15:0] exp_addr [$];
	logic [15:0] exp_data [$];
	logic [1:0] exp_en [$];

	cpu_top cpu_top_i (
		.clk(clk), .reset(reset), .iread_addr(iread_addr), .iread_data(iread_data),
		.dread_addr(dread_addr), .dread_data(dread_data), .dwrite_addr(dwrite_addr),
		.dwrite_data(dwrite_data), .dwrite_en(dwrite_en), .interrupt(interrupt),
		.trap(trap)
	);

	bind cpu_top cpu_tb_chk chk_i (
		.clk(clk), .reset(reset), .dwrite_en(dwrite_en), .trap(trap), .state(state)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// one-cycle synchronous memories, little endian
	always @(posedge clk)
	begin
		iread_data <= {imem[iread_addr + 16'd2], imem[iread_addr + 16'd1], imem[iread_addr]};
		dread_data <= {dmem[dread_addr + 16'd1], dmem[dread_addr]};
		if (dwrite_en[0])
			dmem[dwrite_addr] <= dwrite_data[7:0];
		if (dwrite_en[1])
			dmem[dwrite_addr + 16'd1] <= dwrite_data[15:8];
	end

	// stores are logged mid-cycle where the ports are settled
	always @(negedge clk)
	begin
		if (!reset && dwrite_en != 2'b00)
		begin
			log_addr.push_back(dwrite_addr);
			log_data.push_back(dwrite_data);
			log_en.push_back(dwrite_en);
		end
	end

	task automatic put_byte(input logic [7:0] value);
		imem[asm_addr] = value;
		asm_addr = asm_addr + 16'd1;
	endtask

	task automatic write_op(input cpu_pkg::opcode_t op);
		put_byte(op);
		insn_count++;
	endtask

	task automatic op_with_byte(input cpu_pkg::opcode_t op, input logic [7:0] value);
		write_op(op);
		put_byte(value);
	endtask

	task automatic op_with_word(input cpu_pkg::opcode_t op, input logic [15:0] value);
		write_op(op);
		put_byte(value[7:0]);
		put_byte(value[15:8]);
	endtask

	task automatic expect_store(input logic [15:0] addr, input logic [15:0] data,
		input logic [1:0] en);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
		exp_en.push_back(en);
	endtask

	task automatic check_value(input string name, input int index, input logic [15:0] got,
		input logic [15:0] expected);
		assert (got === expected)
		else
		begin
			$display("Mismatch %s in write %0d: expected %h, got %h", name, index, expected, got);
			errors++;
		end
	endtask

	task automatic start_test();
		int a;
		@(posedge clk);
		#2;
		reset = 1'b1;
		interrupt = 1'b0;
		errors_at_start = errors;
		insn_count = 0;
		exp_addr.delete();
		exp_data.delete();
		exp_en.delete();
		for (a = 0; a < 65536; a++)
		begin
			imem[a[15:0]] = cpu_pkg::OP_TRAP;
			dmem[a[15:0]] = a[15:8] ^ a[7:0] ^ 8'h3c;
		end
		asm_addr = `CPU_RESET_VECTOR;
	endtask

	task automatic release_reset();
		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		log_addr.delete();
		log_data.delete();
		log_en.delete();
		reset = 1'b0;
	endtask

	task automatic wait_for_trap();
		int cycles;
		cycles = 0;
		while (!trap && cycles < 3 * insn_count + 20)
		begin
			@(negedge clk);
			cycles++;
		end
		assert (trap)
		else
		begin
			$display("trap not raised within %0d cycles", cycles);
			errors++;
		end
	endtask

	task automatic compare_writes();
		logic [15:0] mask;
		int i;
		assert (log_addr.size() == exp_addr.size())
		else
		begin
			$display("expected %0d data memory writes, saw %0d", exp_addr.size(),
				log_addr.size());
			errors++;
		end
		for (i = 0; i < exp_addr.size() && i < log_addr.size(); i++)
		begin
			// bytes outside the enable are don't care
			mask = {{8{exp_en[i][1]}}, {8{exp_en[i][0]}}};
			check_value("dwrite_addr", i, log_addr[i], exp_addr[i]);
			check_value("dwrite_en", i, {14'h0, log_en[i]}, {14'h0, exp_en[i]});
			check_value("dwrite_data", i, log_data[i] & mask, exp_data[i] & mask);
		end
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors == errors_at_start)
			$display("%s: pass", name);
		else
		begin
			tests_failed++;
			$display("%s: %0d errors", name, errors - errors_at_start);
		end
	endtask

	task automatic test_load_store();
		start_test();
		op_with_byte(cpu_pkg::OP_LD_XL_IMM, 8'ha5);
		op_with_word(cpu_pkg::OP_LD_DIR_XL, 16'h0100);
		op_with_word(cpu_pkg::OP_LDW_Y_IMM, 16'hbeef);
		op_with_word(cpu_pkg::OP_LDW_DIR_Y, 16'h0102);
		write_op(cpu_pkg::OP_TRAP);
		expect_store(16'h0100, 16'h00a5, 2'b01);
		expect_store(16'h0102, 16'hbeef, 2'b11);
		release_reset();
		wait_for_trap();
		compare_writes();
		end_test("load_store");
	endtask

	task automatic test_alu();
		cpu_pkg::opcode_t op;
		logic [7:0] a;
		logic [7:0] b;
		logic [7:0] expected;
		logic [8:0] sum;
		logic carry;
		logic [15:0] slot;
		int pair;
		int k;
		start_test();
		carry = 1'b0;
		slot = 16'h0000;
		for (pair = 0; pair < 4; pair++)
		begin
			a = 8'($urandom());
			b = 8'($urandom());
			for (k = 0; k < 5; k++)
			begin
				case (k)
					0: op = cpu_pkg::OP_ADD_IMM;
					1: op = cpu_pkg::OP_SUB_IMM;
					2: op = cpu_pkg::OP_AND_IMM;
					3: op = cpu_pkg::OP_OR_IMM;
					default: op = cpu_pkg::OP_XOR_IMM;
				endcase
				case (k)
					0: expected = a + b;
					1: expected = a - b;
					2: expected = a & b;
					3: expected = a | b;
					default: expected = a ^ b;
				endcase
				// logic ops leave carry alone, sub borrows when a < b
				sum = {1'b0, a} + {1'b0, b};
				if (k == 0)
					carry = sum[8];
				else if (k == 1)
					carry = a < b;
				op_with_byte(cpu_pkg::OP_LD_XL_IMM, a);
				op_with_byte(op, b);
				op_with_word(cpu_pkg::OP_LD_DIR_XL, 16'h0200 + slot);
				// jrc lands on the marker, otherwise jr skips it
				op_with_byte(cpu_pkg::OP_JRC, 8'd4);
				op_with_byte(cpu_pkg::OP_JR, 8'd7);
				op_with_byte(cpu_pkg::OP_LD_XL_IMM, 8'h80 | slot[7:0]);
				op_with_word(cpu_pkg::OP_LD_DIR_XL, 16'h0280 + slot);
				expect_store(16'h0200 + slot, {8'h00, expected}, 2'b01);
				if (carry)
					expect_store(16'h0280 + slot, {8'h00, 8'h80 | slot[7:0]}, 2'b01);
				slot = slot + 16'd1;
			end
		end
		write_op(cpu_pkg::OP_TRAP);
		release_reset();
		wait_for_trap();
		compare_writes();
		end_test("alu");
	endtask

	task automatic test_mem_operand();
		logic [7:0] v1;
		logic [7:0] v2;
		logic [7:0] sum8;
		logic [15:0] w0;
		logic [15:0] w1;
		logic [15:0] sum16;
		start_test();
		v1 = 8'($urandom());
		v2 = 8'($urandom());
		w0 = 16'($urandom());
		w1 = 16'($urandom());
		dmem[16'h0400] = v1;
		dmem[16'h0410] = v2;
		dmem[16'h0430] = w0[7:0];
		dmem[16'h0431] = w0[15:8];
		op_with_word(cpu_pkg::OP_LD_XL_DIR, 16'h0400);
		op_with_word(cpu_pkg::OP_ADD_DIR, 16'h0410);
		op_with_word(cpu_pkg::OP_LD_DIR_XL, 16'h0420);
		op_with_word(cpu_pkg::OP_LDW_Y_DIR, 16'h0430);
		op_with_word(cpu_pkg::OP_ADDW_Y_IMM, w1);
		op_with_word(cpu_pkg::OP_LDW_DIR_Y, 16'h0422);
		write_op(cpu_pkg::OP_TRAP);
		sum8 = v1 + v2;
		sum16 = w0 + w1;
		expect_store(16'h0420, {8'h00, sum8}, 2'b01);
		expect_store(16'h0422, sum16, 2'b11);
		release_reset();
		wait_for_trap();
		compare_writes();
		end_test("mem_operand");
	endtask

	task automatic test_branch_call();
		logic [15:0] ret_addr;
		start_test();
		op_with_byte(cpu_pkg::OP_LD_XL_IMM, 8'h33);
		op_with_byte(cpu_pkg::OP_CP_IMM, 8'h33);
		// equal, so z is set
		op_with_byte(cpu_pkg::OP_JRZ, 8'd5);
		op_with_word(cpu_pkg::OP_LD_DIR_XL, 16'h0500);
		op_with_byte(cpu_pkg::OP_JRNZ, 8'd5);
		op_with_word(cpu_pkg::OP_LD_DIR_XL, 16'h0502);
		op_with_byte(cpu_pkg::OP_CP_IMM, 8'h34);
		op_with_byte(cpu_pkg::OP_JRNZ, 8'd5);
		op_with_word(cpu_pkg::OP_LD_DIR_XL, 16'h0504);
		op_with_byte(cpu_pkg::OP_JRZ, 8'd5);
		op_with_word(cpu_pkg::OP_LD_DIR_XL, 16'h0506);
		op_with_word(cpu_pkg::OP_JP, asm_addr + 16'd6);
		op_with_word(cpu_pkg::OP_LD_DIR_XL, 16'h0508);
		ret_addr = asm_addr + 16'd3;
		op_with_word(cpu_pkg::OP_CALL, 16'h4100);
		op_with_word(cpu_pkg::OP_LD_DIR_XL, 16'h0510);
		write_op(cpu_pkg::OP_TRAP);
		asm_addr = 16'h4100;
		op_with_byte(cpu_pkg::OP_LD_XL_IMM, 8'h77);
		write_op(cpu_pkg::OP_RET);
		expect_store(16'h0502, 16'h0033, 2'b01);
		expect_store(16'h0506, 16'h0033, 2'b01);
		expect_store(PUSH_ADDR, ret_addr, 2'b11);
		expect_store(16'h0510, 16'h0077, 2'b01);
		release_reset();
		wait_for_trap();
		compare_writes();
		end_test("branch_call");
	endtask

	task automatic test_interrupt();
		int cycles;
		start_test();
		op_with_word(cpu_pkg::OP_JP, 16'h4010);
		asm_addr = `CPU_INT_VECTOR;
		op_with_byte(cpu_pkg::OP_LD_XL_IMM, 8'h5a);
		op_with_word(cpu_pkg::OP_LD_DIR_XL, 16'h0300);
		write_op(cpu_pkg::OP_RETI);
		// idle loop at 4010
		asm_addr = 16'h4010;
		op_with_byte(cpu_pkg::OP_JR, 8'h00);
		expect_store(PUSH_ADDR, 16'h4010, 2'b11);
		expect_store(16'h0300, 16'h005a, 2'b01);
		release_reset();
		repeat (10) @(posedge clk);
		#2;
		interrupt = 1'b1;
		cycles = 0;
		while (log_addr.size() < 2 && cycles < 40)
		begin
			@(negedge clk);
			cycles++;
		end
		assert (log_addr.size() >= 2)
		else
		begin
			$display("interrupt handler store not seen within %0d cycles", cycles);
			errors++;
		end
		@(posedge clk);
		#2;
		interrupt = 1'b0;
		repeat (30) @(posedge clk);
		compare_writes();
		end_test("interrupt");
	endtask

	task automatic test_trap();
		int i;
		start_test();
		op_with_byte(cpu_pkg::OP_LD_XL_IMM, 8'h11);
		write_op(cpu_pkg::OP_TRAP);
		op_with_word(cpu_pkg::OP_LD_DIR_XL, 16'h0600);
		release_reset();
		wait_for_trap();
		for (i = 0; i < 20; i++)
		begin
			@(negedge clk);
			assert (trap)
			else
			begin
				$display("trap dropped %0d cycles after halting", i);
				errors++;
			end
		end
		compare_writes();
		end_test("trap");
	endtask

	initial
	begin
		reset = 1'b1;
		interrupt = 1'b0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		void'($urandom(32'hff43));
		test_load_store();
		test_alu();
		test_mem_operand();
		test_branch_call();
		test_interrupt();
		test_trap();
		errors = errors + cpu_top_i.chk_i.fail_count;
		$display("%0d tests run, %0d failing, %0d check errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("run exceeded %0d cycles", WATCHDOG_CYCLES);
		$display("tests failed");
		$finish;
	end

endmodule

//--- test/cpu_tb_chk.sv
`timescale 1ns/10ps

module cpu_tb_chk (
	input logic clk,
	input logic reset,
	input logic [1:0] dwrite_en,
	input logic trap,
	input cpu_pkg::state_t state
);

	int fail_count = 0;

	// the cycle after a reset edge never stores
	reset_quiet: assert property (@(posedge clk) reset |=> dwrite_en == 2'b00)
		else
		begin
			fail_count++;
			$error("dwrite_en active after a reset edge");
		end

	halt_quiet: assert property (@(posedge clk) trap |-> dwrite_en == 2'b00)
		else
		begin
			fail_count++;
			$error("dwrite_en active while trap is high");
		end

	// only reset leaves HALT
	trap_sticky: assert property (@(posedge clk) disable iff (reset) trap |=> trap)
		else
		begin
			fail_count++;
			$error("trap fell without reset");
		end

	state_legal: assert property (@(posedge clk) disable iff (reset)
		state inside {cpu_pkg::FETCH, cpu_pkg::EXECUTE, cpu_pkg::MEM_READ,
			cpu_pkg::INT_ENTRY, cpu_pkg::HALT})
		else
		begin
			fail_count++;
			$error("sequencer state outside its encoding");
		end

endmodule

//--- src/cpu_top.sv
`timescale 1ns/10ps
`include "cpu_settings.svh"

module cpu_top (
	input logic clk,
	input logic reset,
	output logic [`CPU_DATA_WIDTH-1:0] iread_addr,
	input logic [`CPU_INST_WIDTH-1:0] iread_data,
	output logic [`CPU_DATA_WIDTH-1:0] dread_addr,
	input logic [`CPU_DATA_WIDTH-1:0] dread_data,
	output logic [`CPU_DATA_WIDTH-1:0] dwrite_addr,
	output logic [`CPU_DATA_WIDTH-1:0] dwrite_data,
	output logic [1:0] dwrite_en,
	input logic interrupt,
	output logic trap
);

	cpu_pkg::state_t state;
	cpu_pkg::opcode_t opcode;
	cpu_pkg::aluop_t aluop;
	cpu_pkg::operand_src_t operand_src;
	logic [`CPU_DATA_WIDTH-1:0] imm;
	logic [`CPU_DATA_WIDTH-1:0] pc;
	logic [`CPU_DATA_WIDTH-1:0] sp;
	logic [`CPU_DATA_WIDTH-1:0] y;
	logic [`CPU_DATA_WIDTH-1:0] jump_target;
	logic [`CPU_DATA_WIDTH-1:0] dec_dwrite_addr;
	logic [`CPU_DATA_WIDTH-1:0] alu_a;
	logic [`CPU_DATA_WIDTH-1:0] alu_b;
	logic [`CPU_DATA_WIDTH-1:0] alu_result;
	logic [7:0] xl;
	logic [3:0] flags;
	logic [3:0] alu_flags;
	logic [3:0] alu_flags_valid;
	logic [3:0] flag_update;
	logic [1:0] length;
	logic [1:0] dec_dwrite_en;
	logic needs_mem;
	logic dec_write_xl;
	logic dec_write_y;
	logic jump;
	logic stack_push;
	logic ret_load;
	logic is_trap;
	logic is_reti;
	logic commit;

	assign iread_addr = pc;
	assign opcode = cpu_pkg::opcode_t'(iread_data[7:0]);
	assign imm = iread_data[23:8];

	cpu_sequencer sequencer_i (
		.clk(clk), .reset(reset), .interrupt(interrupt), .needs_mem(needs_mem),
		.is_trap(is_trap), .is_reti(is_reti), .state(state), .int_active(),
		.trap(trap)
	);

	pc_sp_counter counter_i (
		.clk(clk), .reset(reset), .state(state), .length(length), .jump(jump),
		.jump_target(jump_target), .ret_load(ret_load), .dread_data(dread_data),
		.stack_push(stack_push), .pc(pc), .sp(sp)
	);

	instruction_decoder decoder_i (
		.opcode(opcode), .imm(imm), .pc(pc), .sp(sp), .flags(flags), .aluop(aluop),
		.operand_src(operand_src), .length(length), .needs_mem(needs_mem),
		.write_xl(dec_write_xl), .write_y(dec_write_y), .jump(jump),
		.jump_target(jump_target), .stack_push(stack_push), .ret_load(ret_load),
		.is_trap(is_trap), .is_reti(is_reti), .dread_addr(dread_addr),
		.dwrite_addr(dec_dwrite_addr), .dwrite_en(dec_dwrite_en)
	);

	// only ldw and addw work on y
	assign alu_a = dec_write_y ? y : {8'h00, xl};

	always_comb
	begin
		case (operand_src)
			cpu_pkg::IMM16: alu_b = imm;
			cpu_pkg::MEM: alu_b = dread_data;
			default: alu_b = {8'h00, imm[7:0]};
		endcase
	end

	alu alu_i (
		.aluop(aluop), .a(alu_a), .b(alu_b), .result(alu_result),
		.flags_out(alu_flags), .flags_valid(alu_flags_valid)
	);

	// last cycle of the instruction
	assign commit = (state == cpu_pkg::EXECUTE && !needs_mem) || state == cpu_pkg::MEM_READ;

	// cp is the only flag-setting op that writes no register
	assign flag_update = (commit && (dec_write_xl || dec_write_y || aluop == cpu_pkg::SUB)) ?
		alu_flags_valid : 4'h0;

	register_file regs_i (
		.clk(clk), .reset(reset), .write_xl(commit && dec_write_xl),
		.write_y(commit && dec_write_y), .flag_update(flag_update), .result(alu_result),
		.new_flags(alu_flags), .xl(xl), .y(y), .flags(flags)
	);

	// interrupt entry pushes the pc of the instruction not yet run
	always_comb
	begin
		if (state == cpu_pkg::INT_ENTRY)
		begin
			dwrite_en = 2'b11;
			dwrite_addr = sp - 16'd2;
			dwrite_data = pc;
		end
		else
		begin
			dwrite_en = (state == cpu_pkg::EXECUTE) ? dec_dwrite_en : 2'b00;
			dwrite_addr = dec_dwrite_addr;
			if (stack_push)
				dwrite_data = pc + {{(`CPU_DATA_WIDTH-2){1'b0}}, length};
			else if (dec_dwrite_en == 2'b11)
				dwrite_data = y;
			else
				dwrite_data = {8'h00, xl};
		end
	end

endmodule

//--- src/instruction_decoder.sv
`timescale 1ns/10ps
`include "cpu_settings.svh"

module instruction_decoder (
	input cpu_pkg::opcode_t opcode,
	input logic [`CPU_DATA_WIDTH-1:0] imm,
	input logic [`CPU_DATA_WIDTH-1:0] pc,
	input logic [`CPU_DATA_WIDTH-1:0] sp,
	input logic [3:0] flags,
	output cpu_pkg::aluop_t aluop,
	output cpu_pkg::operand_src_t operand_src,
	output logic [1:0] length,
	output logic needs_mem,
	output logic write_xl,
	output logic write_y,
	output logic jump,
	output logic [`CPU_DATA_WIDTH-1:0] jump_target,
	output logic stack_push,
	output logic ret_load,
	output logic is_trap,
	output logic is_reti,
	output logic [`CPU_DATA_WIDTH-1:0] dread_addr,
	output logic [`CPU_DATA_WIDTH-1:0] dwrite_addr,
	output logic [1:0] dwrite_en
);

	cpu_pkg::aluop_t group_op;
	logic [`CPU_DATA_WIDTH-1:0] rel_target;

	assign rel_target = pc + {{8{imm[7]}}, imm[7:0]};

	// low opcode bits pick the 8-bit operation, cp shares sub
	always_comb
	begin
		case (opcode[2:0])
			3'd0: group_op = cpu_pkg::ADD;
			3'd2: group_op = cpu_pkg::AND;
			3'd3: group_op = cpu_pkg::OR;
			3'd4: group_op = cpu_pkg::XOR;
			default: group_op = cpu_pkg::SUB;
		endcase
	end

	always_comb
	begin
		aluop = cpu_pkg::PASS8;
		operand_src = cpu_pkg::IMM8;
		length = 2'd1;
		needs_mem = 1'b0;
		write_xl = 1'b0;
		write_y = 1'b0;
		jump = 1'b0;
		jump_target = imm;
		stack_push = 1'b0;
		ret_load = 1'b0;
		is_trap = 1'b0;
		is_reti = 1'b0;
		dread_addr = imm;
		dwrite_addr = imm;
		dwrite_en = 2'b00;
		case (opcode)
			cpu_pkg::OP_LD_XL_IMM:
			begin
				length = 2'd2;
				write_xl = 1'b1;
			end
			cpu_pkg::OP_LD_XL_DIR:
			begin
				length = 2'd3;
				operand_src = cpu_pkg::MEM;
				needs_mem = 1'b1;
				write_xl = 1'b1;
			end
			cpu_pkg::OP_LD_DIR_XL:
			begin
				length = 2'd3;
				dwrite_en = 2'b01;
			end
			cpu_pkg::OP_LDW_Y_IMM:
			begin
				length = 2'd3;
				aluop = cpu_pkg::PASS16;
				operand_src = cpu_pkg::IMM16;
				write_y = 1'b1;
			end
			cpu_pkg::OP_LDW_Y_DIR:
			begin
				length = 2'd3;
				aluop = cpu_pkg::PASS16;
				operand_src = cpu_pkg::MEM;
				needs_mem = 1'b1;
				write_y = 1'b1;
			end
			cpu_pkg::OP_LDW_DIR_Y:
			begin
				length = 2'd3;
				dwrite_en = 2'b11;
			end
			cpu_pkg::OP_ADDW_Y_IMM:
			begin
				length = 2'd3;
				aluop = cpu_pkg::ADDW;
				operand_src = cpu_pkg::IMM16;
				write_y = 1'b1;
			end
			cpu_pkg::OP_ADD_IMM, cpu_pkg::OP_SUB_IMM, cpu_pkg::OP_AND_IMM,
			cpu_pkg::OP_OR_IMM, cpu_pkg::OP_XOR_IMM, cpu_pkg::OP_CP_IMM:
			begin
				length = 2'd2;
				aluop = group_op;
				write_xl = (opcode != cpu_pkg::OP_CP_IMM);
			end
			cpu_pkg::OP_ADD_DIR, cpu_pkg::OP_SUB_DIR, cpu_pkg::OP_AND_DIR,
			cpu_pkg::OP_OR_DIR, cpu_pkg::OP_XOR_DIR, cpu_pkg::OP_CP_DIR:
			begin
				length = 2'd3;
				aluop = group_op;
				operand_src = cpu_pkg::MEM;
				needs_mem = 1'b1;
				write_xl = (opcode != cpu_pkg::OP_CP_DIR);
			end
			cpu_pkg::OP_JP:
			begin
				length = 2'd3;
				jump = 1'b1;
			end
			cpu_pkg::OP_CALL:
			begin
				length = 2'd3;
				jump = 1'b1;
				stack_push = 1'b1;
				dwrite_addr = sp - 16'd2;
				dwrite_en = 2'b11;
			end
			cpu_pkg::OP_JR, cpu_pkg::OP_JRZ, cpu_pkg::OP_JRNZ,
			cpu_pkg::OP_JRC, cpu_pkg::OP_JRNC:
			begin
				length = 2'd2;
				jump_target = rel_target;
				case (opcode)
					cpu_pkg::OP_JRZ: jump = flags[cpu_pkg::FLAG_Z];
					cpu_pkg::OP_JRNZ: jump = !flags[cpu_pkg::FLAG_Z];
					cpu_pkg::OP_JRC: jump = flags[cpu_pkg::FLAG_C];
					cpu_pkg::OP_JRNC: jump = !flags[cpu_pkg::FLAG_C];
					default: jump = 1'b1;
				endcase
			end
			cpu_pkg::OP_RET, cpu_pkg::OP_RETI:
			begin
				needs_mem = 1'b1;
				ret_load = 1'b1;
				dread_addr = sp;
				is_reti = (opcode == cpu_pkg::OP_RETI);
			end
			cpu_pkg::OP_TRAP: is_trap = 1'b1;
			default: length = 2'd1;
		endcase
	end

endmodule

//--- src/pc_sp_counter.sv
`timescale 1ns/10ps
`include "cpu_settings.svh"

module pc_sp_counter (
	input logic clk,
	input logic reset,
	input cpu_pkg::state_t state,
	input logic [1:0] length,
	input logic jump,
	input logic [`CPU_DATA_WIDTH-1:0] jump_target,
	input logic ret_load,
	input logic [`CPU_DATA_WIDTH-1:0] dread_data,
	input logic stack_push,
	output logic [`CPU_DATA_WIDTH-1:0] pc,
	output logic [`CPU_DATA_WIDTH-1:0] sp
);

	logic [`CPU_DATA_WIDTH-1:0] seq_pc;

	// next instruction, also the call return address
	assign seq_pc = pc + {{(`CPU_DATA_WIDTH-2){1'b0}}, length};

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pc <= `CPU_RESET_VECTOR;
			sp <= `CPU_STACK_RESET;
		end
		else
		begin
			case (state)
				cpu_pkg::EXECUTE:
				begin
					// instruction word already captured, so pc may move on
					pc <= jump ? jump_target : seq_pc;
					if (stack_push)
						sp <= sp - 16'd2;
				end
				cpu_pkg::MEM_READ:
				begin
					if (ret_load)
					begin
						pc <= dread_data;
						sp <= sp + 16'd2;
					end
				end
				cpu_pkg::INT_ENTRY:
				begin
					pc <= `CPU_INT_VECTOR;
					sp <= sp - 16'd2;
				end
				default:
				begin
					pc <= pc;
					sp <= sp;
				end
			endcase
		end
	end

endmodule

//--- src/cpu_sequencer.sv
`timescale 1ns/10ps

module cpu_sequencer (
	input logic clk,
	input logic reset,
	input logic interrupt,
	input logic needs_mem,
	input logic is_trap,
	input logic is_reti,
	output cpu_pkg::state_t state,
	output logic int_active,
	output logic trap
);

	cpu_pkg::state_t next_state;

	always_comb
	begin
		next_state = state;
		case (state)
			cpu_pkg::FETCH:
			begin
				// interrupt only between instructions, one level deep
				if (interrupt && !int_active)
					next_state = cpu_pkg::INT_ENTRY;
				else
					next_state = cpu_pkg::EXECUTE;
			end
			cpu_pkg::EXECUTE:
			begin
				if (is_trap)
					next_state = cpu_pkg::HALT;
				else if (needs_mem)
					next_state = cpu_pkg::MEM_READ;
				else
					next_state = cpu_pkg::FETCH;
			end
			cpu_pkg::MEM_READ: next_state = cpu_pkg::FETCH;
			cpu_pkg::INT_ENTRY: next_state = cpu_pkg::FETCH;
			cpu_pkg::HALT: next_state = cpu_pkg::HALT;
			default: next_state = cpu_pkg::FETCH;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= cpu_pkg::FETCH;
			int_active <= 1'b0;
		end
		else
		begin
			state <= next_state;
			if (state == cpu_pkg::INT_ENTRY)
				int_active <= 1'b1;
			// reti pops its return address in MEM_READ
			else if (state == cpu_pkg::MEM_READ && is_reti)
				int_active <= 1'b0;
		end
	end

	// held until reset
	assign trap = (state == cpu_pkg::HALT);

endmodule

//--- src/alu.sv
`timescale 1ns/10ps
`include "cpu_settings.svh"

module alu (
	input cpu_pkg::aluop_t aluop,
	input logic [`CPU_DATA_WIDTH-1:0] a,
	input logic [`CPU_DATA_WIDTH-1:0] b,
	output logic [`CPU_DATA_WIDTH-1:0] result,
	output logic [3:0] flags_out,
	output logic [3:0] flags_valid
);

	logic [8:0] sum8;
	logic [8:0] diff8;
	logic [16:0] sum16;
	logic wide;
	logic arith;
	logic carry;
	logic overflow;

	assign sum8 = {1'b0, a[7:0]} + {1'b0, b[7:0]};
	assign diff8 = {1'b0, a[7:0]} - {1'b0, b[7:0]};
	assign sum16 = {1'b0, a} + {1'b0, b};

	always_comb
	begin
		result = '0;
		wide = 1'b0;
		arith = 1'b0;
		carry = 1'b0;
		overflow = 1'b0;
		case (aluop)
			cpu_pkg::PASS8: result = {8'h00, b[7:0]};
			cpu_pkg::PASS16:
			begin
				result = b;
				wide = 1'b1;
			end
			cpu_pkg::ADD:
			begin
				result = {8'h00, sum8[7:0]};
				arith = 1'b1;
				carry = sum8[8];
				overflow = (a[7] == b[7]) && (sum8[7] != a[7]);
			end
			cpu_pkg::SUB:
			begin
				// carry is the borrow, set when a < b unsigned
				result = {8'h00, diff8[7:0]};
				arith = 1'b1;
				carry = diff8[8];
				overflow = (a[7] != b[7]) && (diff8[7] != a[7]);
			end
			cpu_pkg::AND: result = {8'h00, a[7:0] & b[7:0]};
			cpu_pkg::OR: result = {8'h00, a[7:0] | b[7:0]};
			cpu_pkg::XOR: result = {8'h00, a[7:0] ^ b[7:0]};
			cpu_pkg::ADDW:
			begin
				result = sum16[15:0];
				wide = 1'b1;
				arith = 1'b1;
				carry = sum16[16];
				overflow = (a[15] == b[15]) && (sum16[15] != a[15]);
			end
			default: result = '0;
		endcase

		flags_out[cpu_pkg::FLAG_C] = carry;
		flags_out[cpu_pkg::FLAG_O] = overflow;
		flags_out[cpu_pkg::FLAG_Z] = wide ? (result == '0) : (result[7:0] == 8'h00);
		flags_out[cpu_pkg::FLAG_N] = wide ? result[15] : result[7];

		// z and n always, c and o for arithmetic only
		flags_valid[cpu_pkg::FLAG_C] = arith;
		flags_valid[cpu_pkg::FLAG_O] = arith;
		flags_valid[cpu_pkg::FLAG_Z] = 1'b1;
		flags_valid[cpu_pkg::FLAG_N] = 1'b1;
	end

endmodule

//--- src/register_file.sv
`timescale 1ns/10ps
`include "cpu_settings.svh"

module register_file (
	input logic clk,
	input logic reset,
	input logic write_xl,
	input logic write_y,
	input logic [3:0] flag_update,
	input logic [`CPU_DATA_WIDTH-1:0] result,
	input logic [3:0] new_flags,
	output logic [7:0] xl,
	output logic [`CPU_DATA_WIDTH-1:0] y,
	output logic [3:0] flags
);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			xl <= 8'h00;
			y <= '0;
			flags <= 4'h0;
		end
		else
		begin
			if (write_xl)
				xl <= result[7:0];
			if (write_y)
				y <= result;
			// only the flags the operation defines
			flags <= (flags & ~flag_update) | (new_flags & flag_update);
		end
	end

endmodule

//--- src/cpu_pkg.sv
package cpu_pkg;

	// opcode byte; length in bytes in the trailing comment
	// immediates follow the opcode, low byte first
	typedef enum logic [7:0] {
		OP_NOP        = 8'h00, // 1
		OP_TRAP       = 8'h01, // 1
		OP_RET        = 8'h02, // 1
		OP_RETI       = 8'h03, // 1
		OP_LD_XL_IMM  = 8'h10, // 2
		OP_LD_XL_DIR  = 8'h11, // 3
		OP_LD_DIR_XL  = 8'h12, // 3
		OP_LDW_Y_IMM  = 8'h13, // 3
		OP_LDW_Y_DIR  = 8'h14, // 3
		OP_LDW_DIR_Y  = 8'h15, // 3
		OP_ADDW_Y_IMM = 8'h16, // 3
		OP_ADD_IMM    = 8'h20, // 2
		OP_SUB_IMM    = 8'h21, // 2
		OP_AND_IMM    = 8'h22, // 2
		OP_OR_IMM     = 8'h23, // 2
		OP_XOR_IMM    = 8'h24, // 2
		OP_CP_IMM     = 8'h25, // 2
		OP_ADD_DIR    = 8'h28, // 3
		OP_SUB_DIR    = 8'h29, // 3
		OP_AND_DIR    = 8'h2a, // 3
		OP_OR_DIR     = 8'h2b, // 3
		OP_XOR_DIR    = 8'h2c, // 3
		OP_CP_DIR     = 8'h2d, // 3
		OP_JP         = 8'h30, // 3
		OP_CALL       = 8'h31, // 3
		OP_JR         = 8'h38, // 2, signed offset from own address
		OP_JRZ        = 8'h39, // 2
		OP_JRNZ       = 8'h3a, // 2
		OP_JRC        = 8'h3b, // 2
		OP_JRNC       = 8'h3c  // 2
	} opcode_t;

	typedef enum logic [2:0] {
		FETCH     = 3'd0,
		EXECUTE   = 3'd1,
		MEM_READ  = 3'd2,
		INT_ENTRY = 3'd3,
		HALT      = 3'd4
	} state_t;

	typedef enum logic [3:0] {
		PASS8  = 4'd0,
		PASS16 = 4'd1,
		ADD    = 4'd2,
		SUB    = 4'd3,
		AND    = 4'd4,
		OR     = 4'd5,
		XOR    = 4'd6,
		ADDW   = 4'd7
	} aluop_t;

	typedef enum logic [1:0] {
		IMM8  = 2'd0,
		IMM16 = 2'd1,
		MEM   = 2'd2
	} operand_src_t;

	// bit positions in the flag word
	localparam int FLAG_C = 0;
	localparam int FLAG_Z = 1;
	localparam int FLAG_N = 2;
	localparam int FLAG_O = 3;

endpackage

//--- src/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// datapath and instruction word widths
`define CPU_DATA_WIDTH 16
`define CPU_INST_WIDTH 24

// pc after reset
`define CPU_RESET_VECTOR 16'h4000

// single interrupt handler entry
`define CPU_INT_VECTOR 16'h4004

// stack grows down from here
`define CPU_STACK_RESET 16'h0800

`endif
